// File: dv/debug_unit_tb.sv
`timescale 1ns/1ps

module debug_unit_tb;

    localparam int CLKS_PER_BIT  = 4;
    localparam int NUM_REGS      = 4;
    localparam int NUM_MEM_WORDS = 2;
    localparam int IMEM_AW       = 6;
    localparam int SNAP_BYTES    = 4 * (trace_pkg::HEADER_WORDS + NUM_REGS + NUM_MEM_WORDS);
    localparam int PROG_WORDS    = 6;  // Last one is the halt word
    localparam int START_TIMEOUT = 200;
    localparam int LEVEL_TIMEOUT = 400;

    // Latch words seen by the debug unit are pc xor these
    localparam trace_pkg::word_t K_IF_ID   = 32'h1111_0000;
    localparam trace_pkg::word_t K_ID_EX   = 32'h2222_0000;
    localparam trace_pkg::word_t K_EX_MEM  = 32'h4444_0000;
    localparam trace_pkg::word_t K_MEM_WB  = 32'h8888_0000;
    localparam trace_pkg::word_t COLLECT_K = 32'h0001_0011;

    logic                   clk;
    logic                   reset;
    logic                   rx;
    logic                   tx;
    trace_pkg::word_t       pc;
    trace_pkg::word_t       latch_if_id;
    trace_pkg::word_t       latch_id_ex;
    trace_pkg::word_t       latch_ex_mem;
    trace_pkg::word_t       latch_mem_wb;
    logic                   halt;
    trace_pkg::word_t       collect_word;
    logic                   collect_restart;
    logic                   collect_next;
    logic                   collect_mem;
    logic                   cpu_reset;
    logic                   cpu_clk_en;
    logic                   imem_we;
    logic [IMEM_AW-1:0]     imem_addr;
    trace_pkg::word_t       imem_wdata;

    trace_pkg::word_t       stop_pc;
    trace_pkg::word_t       collect_idx;
    trace_pkg::word_t       en_count;
    trace_pkg::word_t       en_before;
    trace_pkg::word_t       counted;
    trace_pkg::word_t       prog [PROG_WORDS];
    logic [IMEM_AW-1:0]     we_addr_q [$];
    trace_pkg::word_t       we_data_q [$];
    int unsigned            seed_init;
    int                     run_len;
    int                     waited;

    debug_unit_top #(
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .NUM_REGS      (NUM_REGS),
        .NUM_MEM_WORDS (NUM_MEM_WORDS),
        .IMEM_AW       (IMEM_AW)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .tx              (tx),
        .pc              (pc),
        .latch_if_id     (latch_if_id),
        .latch_id_ex     (latch_id_ex),
        .latch_ex_mem    (latch_ex_mem),
        .latch_mem_wb    (latch_mem_wb),
        .halt            (halt),
        .collect_word    (collect_word),
        .collect_restart (collect_restart),
        .collect_next    (collect_next),
        .collect_mem     (collect_mem),
        .cpu_reset       (cpu_reset),
        .cpu_clk_en      (cpu_clk_en),
        .imem_we         (imem_we),
        .imem_addr       (imem_addr),
        .imem_wdata      (imem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Processor and collector models

    assign latch_if_id  = pc ^ K_IF_ID;
    assign latch_id_ex  = pc ^ K_ID_EX;
    assign latch_ex_mem = pc ^ K_EX_MEM;
    assign latch_mem_wb = pc ^ K_MEM_WB;
    assign halt         = (pc == stop_pc);
    assign collect_word = collect_idx * COLLECT_K + ((collect_mem === 1'b1) ? 32'h100 : 32'h0);

    always @(posedge clk) begin
        if (cpu_reset === 1'b1) begin
            pc <= '0;
        end else if (cpu_clk_en === 1'b1) begin
            pc <= pc + 32'd4;
        end
    end

    always @(posedge clk) begin
        if (collect_restart === 1'b1) begin
            collect_idx <= '0;
        end else if (collect_next === 1'b1) begin
            collect_idx <= collect_idx + 32'd1;
        end
    end

    // Observers
    always @(negedge clk) begin
        if (cpu_clk_en === 1'b1) begin
            en_count <= en_count + 32'd1;
        end
        if (imem_we === 1'b1) begin
            we_addr_q.push_back(imem_addr);
            we_data_q.push_back(imem_wdata);
        end
    end

    ////////////////////
    // Reference and checks

    function automatic debug_proto_pkg::byte_t snapshot_byte(input int n,
                                                             input trace_pkg::word_t pc_v,
                                                             input trace_pkg::word_t count_v);
        int               w;
        int               c;
        trace_pkg::word_t word;
        w = n / 4;
        case (w)
            0: word = pc_v;
            1: word = pc_v ^ K_IF_ID;
            2: word = pc_v ^ K_ID_EX;
            3: word = pc_v ^ K_EX_MEM;
            4: word = pc_v ^ K_MEM_WB;
            5: word = count_v;
            default: begin
                c    = w - trace_pkg::HEADER_WORDS;
                word = c * COLLECT_K;
                if (c >= NUM_REGS) begin
                    word = word + 32'h100;  // Data memory words
                end
            end
        endcase
        return word[(n % 4) * 8 +: 8];
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input debug_proto_pkg::byte_t got,
                              input debug_proto_pkg::byte_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %02h expected %02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_word(input trace_pkg::word_t got, input trace_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %08h expected %08h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    ////////////////////
    // UART host side

    task automatic send_byte(input debug_proto_pkg::byte_t b);
        int i;
        @(posedge clk);
        rx <= 1'b0;
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            rx <= b[i];
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic receive_byte(output debug_proto_pkg::byte_t b, input string what);
        int                     i;
        int                     wait_cnt;
        debug_proto_pkg::byte_t data;
        wait_cnt = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            wait_cnt++;
            if (wait_cnt > START_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for a start bit on tx for %s", what));
            end
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
        check_level(tx, 1'b0, "tx start bit");
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_level(tx, 1'b1, "tx stop bit");
        b = data;
    endtask

    task automatic receive_snapshot(input trace_pkg::word_t exp_pc,
                                    input trace_pkg::word_t exp_count);
        int                     n;
        debug_proto_pkg::byte_t b;
        for (n = 0; n < SNAP_BYTES; n++) begin
            receive_byte(b, $sformatf("snapshot byte %0d", n));
            check_byte(b, snapshot_byte(n, exp_pc, exp_count),
                       $sformatf("snapshot byte %0d", n));
        end
    endtask

    task automatic quiet_window(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            check_level(cpu_clk_en, 1'b0, {what, " cpu_clk_en"});
            check_level(imem_we, 1'b0, {what, " imem_we"});
            check_level(tx, 1'b1, {what, " tx idle"});
        end
    endtask

    task automatic wait_cpu_reset(input logic level, input string what);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (cpu_reset !== level) begin
            wait_cnt++;
            if (wait_cnt > LEVEL_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for cpu_reset to be %b %s", level, what));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_halt();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (halt !== 1'b1) begin
            wait_cnt++;
            if (wait_cnt > LEVEL_TIMEOUT) begin
                abort_run("Timed out waiting for the processor model to halt");
            end
            @(negedge clk);
        end
    endtask

    ////////////////////
    // Scenarios

    initial begin
        reset       = 1'b1;
        rx          = 1'b1;
        pc          = '0;
        stop_pc     = 32'hFFFF_FFF0;
        collect_idx = '0;
        en_count    = '0;
        seed_init   = $urandom(32'h4639dc88);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_level(cpu_reset, 1'b1, "cpu_reset after reset");
        check_level(cpu_clk_en, 1'b0, "cpu_clk_en after reset");
        check_level(imem_we, 1'b0, "imem_we after reset");
        check_level(collect_next, 1'b0, "collect_next after reset");
        check_level(tx, 1'b1, "tx after reset");

        // Program load, halt word last
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            prog[i] = $urandom;
            if (prog[i][31:26] == debug_proto_pkg::HALT_OPCODE) begin
                prog[i][31] = 1'b0;
            end
        end
        prog[PROG_WORDS-1] = {debug_proto_pkg::HALT_OPCODE, 26'($urandom)};
        send_byte(debug_proto_pkg::CMD_PROGRAM);
        for (int i = 0; i < PROG_WORDS; i++) begin
            for (int lane = 0; lane < 4; lane++) begin
                send_byte(prog[i][lane*8 +: 8]);
            end
        end
        waited = 0;
        while (we_data_q.size() < PROG_WORDS) begin
            @(negedge clk);
            waited++;
            if (waited > LEVEL_TIMEOUT) begin
                abort_run("Timed out waiting for instruction memory writes");
            end
        end
        send_byte(8'h00);  // A full word of bytes after the halt word, not program data
        send_byte(8'h5A);
        send_byte(8'hC3);
        send_byte(8'h7E);
        quiet_window(80, "after load");
        check_word(we_data_q.size(), PROG_WORDS, "instruction write count");
        for (int i = 0; i < PROG_WORDS; i++) begin
            check_word(32'(we_addr_q[i]), i, $sformatf("imem_addr of word %0d", i));
            check_word(we_data_q[i], prog[i], $sformatf("imem_wdata of word %0d", i));
        end

        // Unknown command in WAIT_CMD
        send_byte(8'hA5);
        quiet_window(100, "unknown command");

        // Continuous run until halt
        run_len = 3 + ($urandom % 6);
        @(posedge clk);
        stop_pc <= 32'(run_len * 4);
        en_before = en_count;
        send_byte(debug_proto_pkg::CMD_CONTINUOUS);
        wait_halt();
        counted = en_count - en_before;
        check_word(counted, run_len, "run cycles before halt");
        receive_snapshot(32'(run_len * 4), counted);
        wait_cpu_reset(1'b1, "after halt snapshot");

        // Step mode, two single steps
        @(posedge clk);
        stop_pc <= 32'hFFFF_FFF0;
        send_byte(debug_proto_pkg::CMD_STEP_MODE);
        wait_cpu_reset(1'b0, "after step mode");
        for (int s = 1; s <= 2; s++) begin
            en_before = en_count;
            send_byte(debug_proto_pkg::CMD_STEP);
            receive_snapshot(32'(s * 4), s);
            check_word(en_count - en_before, 1, $sformatf("step %0d clock enables", s));
            check_level(cpu_reset, 1'b0, "cpu_reset in step mode");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: src/debug_ctrl.sv
`timescale 1ns/1ps

module debug_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx_valid,
    input  debug_proto_pkg::byte_t rx_byte,
    input  logic                   halt,
    input  logic                   load_done,
    input  logic                   dump_done,
    output logic                   load_start,
    output logic                   load_active,
    output logic                   dump_start,
    output trace_pkg::word_t       cycle_count,
    output logic                   cpu_reset,
    output logic                   cpu_clk_en
);

    typedef enum logic [2:0] {WAIT_CMD, LOAD, RUN, STEP_WAIT, DUMP} state_t;

    state_t                state;
    debug_proto_pkg::cmd_t cmd;
    logic                  step_q;  // One processor cycle per step

    assign cmd         = debug_proto_pkg::cmd_t'(rx_byte);
    assign load_active = (state == LOAD);

    // Halt cycle itself is not clocked
    assign cpu_clk_en = step_q || (state == RUN && !halt);

    ////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= WAIT_CMD;
            cpu_reset   <= 1'b1;
            step_q      <= 1'b0;
            load_start  <= 1'b0;
            dump_start  <= 1'b0;
            cycle_count <= '0;
        end else begin
            load_start <= 1'b0;
            step_q     <= 1'b0;
            dump_start <= step_q;  // Snapshot after the stepped cycle
            case (state)
                WAIT_CMD: begin
                    if (rx_valid) begin
                        case (cmd)
                            debug_proto_pkg::CMD_PROGRAM: begin
                                state      <= LOAD;
                                load_start <= 1'b1;
                            end
                            debug_proto_pkg::CMD_CONTINUOUS: begin
                                state       <= RUN;
                                cpu_reset   <= 1'b0;
                                cycle_count <= '0;
                            end
                            debug_proto_pkg::CMD_STEP_MODE: begin
                                state       <= STEP_WAIT;
                                cpu_reset   <= 1'b0;
                                cycle_count <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        state <= WAIT_CMD;
                    end
                end
                RUN: begin
                    if (halt) begin
                        state      <= DUMP;
                        dump_start <= 1'b1;
                    end else begin
                        cycle_count <= cycle_count + 32'd1;
                    end
                end
                STEP_WAIT: begin
                    if (rx_valid && cmd == debug_proto_pkg::CMD_STEP) begin
                        step_q      <= 1'b1;
                        cycle_count <= cycle_count + 32'd1;
                        state       <= DUMP;
                    end
                end
                DUMP: begin
                    if (dump_done) begin
                        state     <= halt ? WAIT_CMD : STEP_WAIT;
                        cpu_reset <= halt;  // Halted core goes back into reset
                    end
                end
                default: state <= WAIT_CMD;
            endcase
        end
    end

endmodule

// File: src/debug_proto_pkg.sv
package debug_proto_pkg;

    ////////////////////
    // Host link types

    typedef logic [7:0] byte_t;

    // Command bytes sent by the host
    typedef enum logic [7:0] {
        CMD_PROGRAM    = 8'h01,
        CMD_CONTINUOUS = 8'h02,
        CMD_STEP_MODE  = 8'h03,
        CMD_STEP       = 8'h06
    } cmd_t;

    ////////////////////
    // Program load

    // Top six bits of the instruction that ends a load
    localparam logic [5:0] HALT_OPCODE = 6'b111111;

endpackage

// File: src/debug_unit_top.sv
`timescale 1ns/1ps

module debug_unit_top #(
    parameter int CLKS_PER_BIT  = 16,
    parameter int NUM_REGS      = 32,
    parameter int NUM_MEM_WORDS = 16,
    parameter int IMEM_AW       = 6
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx,
    output logic               tx,
    input  trace_pkg::word_t   pc,
    input  trace_pkg::word_t   latch_if_id,
    input  trace_pkg::word_t   latch_id_ex,
    input  trace_pkg::word_t   latch_ex_mem,
    input  trace_pkg::word_t   latch_mem_wb,
    input  logic               halt,
    input  trace_pkg::word_t   collect_word,
    output logic               collect_restart,
    output logic               collect_next,
    output logic               collect_mem,
    output logic               cpu_reset,
    output logic               cpu_clk_en,
    output logic               imem_we,
    output logic [IMEM_AW-1:0] imem_addr,
    output trace_pkg::word_t   imem_wdata
);

    debug_proto_pkg::byte_t rx_byte;
    debug_proto_pkg::byte_t tx_byte;
    logic                   rx_valid;
    logic                   tx_start;
    logic                   tx_busy;
    logic                   tx_done;
    logic                   load_start;
    logic                   load_active;
    logic                   load_done;
    logic                   dump_start;
    logic                   dump_done;
    trace_pkg::word_t       cycle_count;

    ////////////////////
    // UART

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    ////////////////////
    // Control and datapath

    debug_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .halt        (halt),
        .load_done   (load_done),
        .dump_done   (dump_done),
        .load_start  (load_start),
        .load_active (load_active),
        .dump_start  (dump_start),
        .cycle_count (cycle_count),
        .cpu_reset   (cpu_reset),
        .cpu_clk_en  (cpu_clk_en)
    );

    program_loader #(.IMEM_AW(IMEM_AW)) u_loader (
        .clk         (clk),
        .reset       (reset),
        .load_start  (load_start),
        .load_active (load_active),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .load_done   (load_done)
    );

    snapshot_serializer #(
        .NUM_REGS      (NUM_REGS),
        .NUM_MEM_WORDS (NUM_MEM_WORDS)
    ) u_snap (
        .clk             (clk),
        .reset           (reset),
        .dump_start      (dump_start),
        .cycle_count     (cycle_count),
        .pc              (pc),
        .latch_if_id     (latch_if_id),
        .latch_id_ex     (latch_id_ex),
        .latch_ex_mem    (latch_ex_mem),
        .latch_mem_wb    (latch_mem_wb),
        .collect_word    (collect_word),
        .tx_busy         (tx_busy),
        .tx_done         (tx_done),
        .tx_start        (tx_start),
        .tx_byte         (tx_byte),
        .collect_restart (collect_restart),
        .collect_next    (collect_next),
        .collect_mem     (collect_mem),
        .dump_done       (dump_done)
    );

endmodule

// File: src/program_loader.sv
`timescale 1ns/1ps

module program_loader #(
    parameter int IMEM_AW = 6
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_start,
    input  logic                   load_active,
    input  logic                   rx_valid,
    input  debug_proto_pkg::byte_t rx_byte,
    output logic                   imem_we,
    output logic [IMEM_AW-1:0]     imem_addr,
    output trace_pkg::word_t       imem_wdata,
    output logic                   load_done
);

    logic [1:0] lane;
    logic       take;

    assign take = load_active && rx_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            lane      <= '0;
            imem_addr <= '0;
            imem_we   <= 1'b0;
            load_done <= 1'b0;
        end else begin
            imem_we   <= 1'b0;
            load_done <= 1'b0;
            if (imem_we) begin
                imem_addr <= imem_addr + 1'b1;  // Advance after each write
            end
            if (load_start) begin
                lane      <= '0;
                imem_addr <= '0;
            end else if (take) begin
                lane <= lane + 2'd1;
                if (lane == 2'd3) begin
                    imem_we <= 1'b1;
                    // Last byte holds word bits 31:26
                    load_done <= (rx_byte[7:2] == debug_proto_pkg::HALT_OPCODE);
                end
            end
        end
    end

    // Little-endian assembly, low lane first
    always_ff @(posedge clk) begin
        if (take) begin
            imem_wdata[{lane, 3'b000} +: 8] <= rx_byte;
        end
    end

endmodule

// File: src/snapshot_serializer.sv
`timescale 1ns/1ps

module snapshot_serializer #(
    parameter int NUM_REGS      = 32,
    parameter int NUM_MEM_WORDS = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dump_start,
    input  trace_pkg::word_t       cycle_count,
    input  trace_pkg::word_t       pc,
    input  trace_pkg::word_t       latch_if_id,
    input  trace_pkg::word_t       latch_id_ex,
    input  trace_pkg::word_t       latch_ex_mem,
    input  trace_pkg::word_t       latch_mem_wb,
    input  trace_pkg::word_t       collect_word,
    input  logic                   tx_busy,
    input  logic                   tx_done,
    output logic                   tx_start,
    output debug_proto_pkg::byte_t tx_byte,
    output logic                   collect_restart,
    output logic                   collect_next,
    output logic                   collect_mem,
    output logic                   dump_done
);

    localparam int TOTAL_WORDS = trace_pkg::HEADER_WORDS + NUM_REGS + NUM_MEM_WORDS;
    localparam int MEM_BASE    = trace_pkg::HEADER_WORDS + NUM_REGS;
    localparam int IDX_W       = $clog2(TOTAL_WORDS);

    typedef enum logic [1:0] {IDLE, SEND, WAIT_TX} state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic [1:0]       lane;
    logic             word_end;
    trace_pkg::word_t cur_word;

    ////////////////////
    // Byte select

    always_comb begin
        case (idx)
            IDX_W'(trace_pkg::HDR_PC):     cur_word = pc;
            IDX_W'(trace_pkg::HDR_IF_ID):  cur_word = latch_if_id;
            IDX_W'(trace_pkg::HDR_ID_EX):  cur_word = latch_id_ex;
            IDX_W'(trace_pkg::HDR_EX_MEM): cur_word = latch_ex_mem;
            IDX_W'(trace_pkg::HDR_MEM_WB): cur_word = latch_mem_wb;
            IDX_W'(trace_pkg::HDR_CYCLES): cur_word = cycle_count;
            default:                       cur_word = collect_word;
        endcase
    end

    assign tx_byte  = cur_word[{lane, 3'b000} +: 8];  // Low byte first
    assign tx_start = (state == SEND) && !tx_busy;
    assign word_end = (state == WAIT_TX) && tx_done &&
                      (lane == 2'(trace_pkg::BYTES_PER_WORD - 1));

    // Collector steps right away so its word is ready for the next send
    assign collect_restart = dump_start;
    assign collect_next    = word_end && (idx >= IDX_W'(trace_pkg::HEADER_WORDS));
    assign collect_mem     = (state != IDLE) && (idx >= IDX_W'(MEM_BASE));

    ////////////////////
    // Word and lane walk

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            idx       <= '0;
            lane      <= '0;
            dump_done <= 1'b0;
        end else begin
            dump_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (dump_start) begin
                        idx   <= '0;
                        lane  <= '0;
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (!tx_busy) begin
                        state <= WAIT_TX;
                    end
                end
                WAIT_TX: begin
                    if (tx_done) begin
                        lane  <= lane + 2'd1;  // Wraps at word end
                        state <= SEND;
                        if (word_end) begin
                            if (idx == IDX_W'(TOTAL_WORDS - 1)) begin
                                state     <= IDLE;
                                dump_done <= 1'b1;
                            end else begin
                                idx <= idx + 1'b1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/trace_pkg.sv
package trace_pkg;

    typedef logic [31:0] word_t;

    localparam int BYTES_PER_WORD = 4;

    ////////////////////
    // Snapshot header, word positions in send order

    localparam int HDR_PC     = 0;
    localparam int HDR_IF_ID  = 1;
    localparam int HDR_ID_EX  = 2;
    localparam int HDR_EX_MEM = 3;
    localparam int HDR_MEM_WB = 4;
    localparam int HDR_CYCLES = 5;

    localparam int HEADER_WORDS = 6;  // Collector words follow

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    output debug_proto_pkg::byte_t rx_byte,
    output logic                   rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t           state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;
    logic             mid_start;
    logic             rx_s;

    assign rx_s      = rx_sync[1];
    assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign mid_start = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync  <= 2'b11;  // Line idles high
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (mid_start) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? IDLE : DATA;  // Glitch, not a start bit
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        rx_valid <= rx_s;  // Framing error drops the byte
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data shifts in LSB first, sampled mid-bit
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tx_start,
    input  debug_proto_pkg::byte_t tx_byte,
    output logic                   tx,
    output logic                   tx_busy,
    output logic                   tx_done
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       frame;  // Data bits then stop bit

    always_ff @(posedge clk) begin
        if (reset) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                if (tx_start) begin
                    tx      <= 1'b0;  // Start bit
                    tx_busy <= 1'b1;
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                    tx      <= 1'b1;
                end else begin
                    tx      <= frame[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_byte};
        end else if (tx_busy && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

// File: vlog.f
src/debug_proto_pkg.sv
src/trace_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_ctrl.sv
src/program_loader.sv
src/snapshot_serializer.sv
src/debug_unit_top.sv
dv/debug_unit_tb.sv
